//--- verilog/rv_pkg.sv
package rv_pkg;

  // ==========================================================================
  // sizes
  // ==========================================================================
  localparam int xlen       = 32;
  localparam int imem_words = 64;
  localparam int imem_aw    = 6;
  localparam int dmem_words = 64;

  // ==========================================================================
  // encodings
  // ==========================================================================
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;

  localparam logic [2:0] alu_add = 3'd0;
  localparam logic [2:0] alu_sub = 3'd1;
  localparam logic [2:0] alu_and = 3'd2;
  localparam logic [2:0] alu_or  = 3'd3;
  localparam logic [2:0] alu_slt = 3'd4;

  localparam logic [1:0] fwd_reg   = 2'd0; // value read in decode.
  localparam logic [1:0] fwd_exmem = 2'd1;
  localparam logic [1:0] fwd_memwb = 2'd2;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // the branch offset is scattered over the word and always even.
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
  } instr_u;

endpackage

//--- verilog/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run,
  input  logic                       stall,
  input  logic                       pc_sel,
  input  logic [rv_pkg::xlen-1:0]    branch_target,
  input  logic                       imem_we,
  input  logic [rv_pkg::imem_aw-1:0] imem_addr,
  input  logic [rv_pkg::xlen-1:0]    imem_wdata,
  output logic [rv_pkg::xlen-1:0]    pc,
  output rv_pkg::instr_u             instr
);

  logic [rv_pkg::xlen-1:0] imem [rv_pkg::imem_words];

  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  assign instr = imem[pc[rv_pkg::imem_aw+1:2]]; // word addressed.

  always_ff @(posedge clk) begin
    if (rst || !run) begin
      pc <= '0;
    end else if (pc_sel) begin
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // the program is only loaded while the core is parked.
  assert property (@(posedge clk) disable iff (rst) !(imem_we && run))
    else $error("instruction memory written while the core runs.");

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::instr_u          instr,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic                    wb_we,
  input  logic [4:0]              wb_rd,
  input  logic [rv_pkg::xlen-1:0] wb_data,
  input  logic                    ex_mem_reg_write,
  input  logic [4:0]              ex_mem_rd,
  input  logic [rv_pkg::xlen-1:0] ex_mem_alu,
  output logic [rv_pkg::xlen-1:0] rdata1,
  output logic [rv_pkg::xlen-1:0] rdata2,
  output logic [rv_pkg::xlen-1:0] imm,
  output logic [4:0]              rs1,
  output logic [4:0]              rs2,
  output logic [4:0]              rd,
  output logic                    branch_taken,
  output logic [rv_pkg::xlen-1:0] branch_target
);

  logic [rv_pkg::xlen-1:0] regs [32];
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] cmp1;
  logic [rv_pkg::xlen-1:0] cmp2;

  // a read of the register being written sees the new value.
  function automatic logic [rv_pkg::xlen-1:0] rf_read(input logic [4:0] idx);
    if (idx == 5'd0) begin
      return '0;
    end else if (wb_we && wb_rd == idx) begin
      return wb_data;
    end
    return regs[idx];
  endfunction

  assign rs1 = instr.r_fmt.rs1;
  assign rs2 = instr.r_fmt.rs2;
  assign rd  = instr.r_fmt.rd;

  always_ff @(posedge clk) begin
    if (!rst && wb_we && wb_rd != 5'd0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_comb begin
    rdata1 = rf_read(rs1);
    rdata2 = rf_read(rs2);
  end

  assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                  instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};

  always_comb begin
    case (instr.r_fmt.opcode)
      rv_pkg::op_itype, rv_pkg::op_load: begin
        imm = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
      end
      rv_pkg::op_store: begin
        imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
      end
      rv_pkg::op_branch: imm = imm_b;
      default:           imm = '0;
    endcase
  end

  // ==========================================================================
  // branch resolution
  // ==========================================================================
  // an ALU result one stage ahead is taken from EX/MEM. loads there are stalled.
  assign cmp1 = (ex_mem_reg_write && ex_mem_rd != 5'd0 && ex_mem_rd == rs1) ? ex_mem_alu
                                                                             : rdata1;
  assign cmp2 = (ex_mem_reg_write && ex_mem_rd != 5'd0 && ex_mem_rd == rs2) ? ex_mem_alu
                                                                             : rdata2;

  assign branch_taken  = (instr.r_fmt.opcode == rv_pkg::op_branch) && (cmp1 == cmp2);
  assign branch_target = pc + imm_b;

endmodule

//--- verilog/pipeline_control.sv
`timescale 1ns/1ns

module pipeline_control (
  input  logic           clk,
  input  logic           rst,
  input  rv_pkg::instr_u if_id_instr,
  input  logic [4:0]     id_ex_rs1,
  input  logic [4:0]     id_ex_rs2,
  input  logic [4:0]     id_ex_rd,
  input  logic           id_ex_mem_read,
  input  logic           id_ex_reg_write,
  input  logic [4:0]     ex_mem_rd,
  input  logic           ex_mem_reg_write,
  input  logic           ex_mem_mem_read,
  input  logic [4:0]     mem_wb_rd,
  input  logic           mem_wb_reg_write,
  input  logic           branch_taken,
  output logic           reg_write,
  output logic           mem_read,
  output logic           mem_write,
  output logic           mem_to_reg,
  output logic           alu_src,
  output logic [2:0]     alu_op,
  output logic           stall,
  output logic           pc_sel,
  output logic           flush_if,
  output logic [1:0]     fwd_a,
  output logic [1:0]     fwd_b
);

  logic [6:0] opcode;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic       use_rs1;
  logic       use_rs2;
  logic       ex_hit;
  logic       mem_hit;
  logic       load_use;
  logic       branch_hazard;
  logic       dec_reg_write;
  logic       dec_mem_read;
  logic       dec_mem_write;
  logic       dec_mem_to_reg;
  logic       dec_alu_src;
  logic [2:0] dec_alu_op;

  function automatic logic [2:0] arith_op(input logic [2:0] funct3, input logic sub);
    case (funct3)
      3'b000:  return sub ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b010:  return rv_pkg::alu_slt;
      3'b110:  return rv_pkg::alu_or;
      3'b111:  return rv_pkg::alu_and;
      default: return rv_pkg::alu_add;
    endcase
  endfunction

  function automatic logic [1:0] fwd_sel(input logic [4:0] src);
    if (ex_mem_reg_write && ex_mem_rd != 5'd0 && ex_mem_rd == src) begin
      return rv_pkg::fwd_exmem;
    end else if (mem_wb_reg_write && mem_wb_rd != 5'd0 && mem_wb_rd == src) begin
      return rv_pkg::fwd_memwb;
    end
    return rv_pkg::fwd_reg;
  endfunction

  assign opcode = if_id_instr.r_fmt.opcode;
  assign rs1    = if_id_instr.r_fmt.rs1;
  assign rs2    = if_id_instr.r_fmt.rs2;

  always_comb begin
    dec_reg_write  = 1'b0;
    dec_mem_read   = 1'b0;
    dec_mem_write  = 1'b0;
    dec_mem_to_reg = 1'b0;
    dec_alu_src    = 1'b0;
    dec_alu_op     = rv_pkg::alu_add;
    case (opcode)
      rv_pkg::op_rtype: begin
        dec_reg_write = 1'b1;
        dec_alu_op    = arith_op(if_id_instr.r_fmt.funct3, if_id_instr.r_fmt.funct7[5]);
      end
      rv_pkg::op_itype: begin
        dec_reg_write = 1'b1;
        dec_alu_src   = 1'b1;
        dec_alu_op    = arith_op(if_id_instr.i_fmt.funct3, 1'b0);
      end
      rv_pkg::op_load: begin
        dec_reg_write  = 1'b1;
        dec_mem_read   = 1'b1;
        dec_mem_to_reg = 1'b1;
        dec_alu_src    = 1'b1;
      end
      rv_pkg::op_store: begin
        dec_mem_write = 1'b1;
        dec_alu_src   = 1'b1;
      end
      default: ; // branches and bubbles write nothing.
    endcase
  end

  // ==========================================================================
  // hazards
  // ==========================================================================
  assign use_rs1 = opcode inside {rv_pkg::op_rtype, rv_pkg::op_itype, rv_pkg::op_load,
                                  rv_pkg::op_store, rv_pkg::op_branch};
  assign use_rs2 = opcode inside {rv_pkg::op_rtype, rv_pkg::op_store, rv_pkg::op_branch};

  assign ex_hit  = (id_ex_rd != 5'd0) &&
                   ((use_rs1 && id_ex_rd == rs1) || (use_rs2 && id_ex_rd == rs2));
  assign mem_hit = (ex_mem_rd != 5'd0) &&
                   ((use_rs1 && ex_mem_rd == rs1) || (use_rs2 && ex_mem_rd == rs2));

  assign load_use      = id_ex_mem_read && ex_hit;
  assign branch_hazard = (opcode == rv_pkg::op_branch) &&
                         ((id_ex_reg_write && ex_hit) || (ex_mem_mem_read && mem_hit));
  assign stall         = load_use || branch_hazard;

  assign reg_write  = dec_reg_write && !stall; // bubble into ID/EX.
  assign mem_read   = dec_mem_read && !stall;
  assign mem_write  = dec_mem_write && !stall;
  assign mem_to_reg = dec_mem_to_reg && !stall;
  assign alu_src    = dec_alu_src && !stall;
  assign alu_op     = stall ? rv_pkg::alu_add : dec_alu_op;

  assign pc_sel   = branch_taken && !stall;
  assign flush_if = pc_sel;

  always_comb begin
    fwd_a = fwd_sel(id_ex_rs1);
    fwd_b = fwd_sel(id_ex_rs2);
  end

  // the bubble behind a load clears the hazard on the next cycle.
  assert property (@(posedge clk) disable iff (rst) load_use |=> !load_use)
    else $error("load-use stall held for more than one cycle.");

  assert property (@(posedge clk) disable iff (rst) pc_sel |=> opcode == 7'd0)
    else $error("instruction behind a taken branch was not flushed.");

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
  input  logic [2:0]              alu_op,
  input  logic                    alu_src,
  input  logic [rv_pkg::xlen-1:0] rdata1,
  input  logic [rv_pkg::xlen-1:0] rdata2,
  input  logic [rv_pkg::xlen-1:0] imm,
  input  logic [1:0]              fwd_a,
  input  logic [1:0]              fwd_b,
  input  logic [rv_pkg::xlen-1:0] ex_mem_alu,
  input  logic [rv_pkg::xlen-1:0] wb_data,
  output logic [rv_pkg::xlen-1:0] alu_result,
  output logic [rv_pkg::xlen-1:0] store_value
);

  logic [rv_pkg::xlen-1:0] op_a;
  logic [rv_pkg::xlen-1:0] op_b;

  function automatic logic [rv_pkg::xlen-1:0] pick(
    input logic [1:0]              sel,
    input logic [rv_pkg::xlen-1:0] reg_val,
    input logic [rv_pkg::xlen-1:0] exmem_val,
    input logic [rv_pkg::xlen-1:0] memwb_val
  );
    case (sel)
      rv_pkg::fwd_exmem: return exmem_val;
      rv_pkg::fwd_memwb: return memwb_val;
      default:           return reg_val;
    endcase
  endfunction

  assign op_a        = pick(fwd_a, rdata1, ex_mem_alu, wb_data);
  assign store_value = pick(fwd_b, rdata2, ex_mem_alu, wb_data);
  assign op_b        = alu_src ? imm : store_value;

  always_comb begin
    case (alu_op)
      rv_pkg::alu_sub: alu_result = op_a - op_b;
      rv_pkg::alu_and: alu_result = op_a & op_b;
      rv_pkg::alu_or:  alu_result = op_a | op_b;
      rv_pkg::alu_slt: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
      default:         alu_result = op_a + op_b; // also the address for lw and sw.
    endcase
  end

endmodule

//--- verilog/memory_stage.sv
`timescale 1ns/1ns

module memory_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    mem_read,
  input  logic                    mem_write,
  input  logic [rv_pkg::xlen-1:0] addr,
  input  logic [rv_pkg::xlen-1:0] wdata,
  output logic [rv_pkg::xlen-1:0] rdata,
  output logic                    store_valid,
  output logic [rv_pkg::xlen-1:0] store_addr,
  output logic [rv_pkg::xlen-1:0] store_data
);

  logic [rv_pkg::xlen-1:0]                dmem [rv_pkg::dmem_words];
  logic [$clog2(rv_pkg::dmem_words)-1:0]  word_idx;

  assign word_idx = addr[$clog2(rv_pkg::dmem_words)+1:2];

  always_ff @(posedge clk) begin
    if (mem_write && !rst) begin
      dmem[word_idx] <= wdata;
    end
  end

  assign rdata = mem_read ? dmem[word_idx] : '0;

  // every write is also seen outside the core.
  assign store_valid = mem_write;
  assign store_addr  = addr;
  assign store_data  = wdata;

  assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
    else $error("load and store in the same slot.");

  assert property (@(posedge clk) disable iff (rst) (mem_read || mem_write) |-> addr[1:0] == 2'b00)
    else $error("misaligned data access.");

endmodule

//--- verilog/rv_pipeline.sv
`timescale 1ns/1ns

module rv_pipeline (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run,
  input  logic                       imem_we,
  input  logic [rv_pkg::imem_aw-1:0] imem_addr,
  input  logic [rv_pkg::xlen-1:0]    imem_wdata,
  output logic                       store_valid,
  output logic [rv_pkg::xlen-1:0]    store_addr,
  output logic [rv_pkg::xlen-1:0]    store_data
);

  // stage outputs and control.
  logic [rv_pkg::xlen-1:0] fetch_pc;
  rv_pkg::instr_u          fetch_instr;
  logic                    ctl_reg_write;
  logic                    ctl_mem_read;
  logic                    ctl_mem_write;
  logic                    ctl_mem_to_reg;
  logic                    ctl_alu_src;
  logic [2:0]              ctl_alu_op;
  logic                    stall;
  logic                    pc_sel;
  logic                    flush_if;
  logic [1:0]              fwd_a;
  logic [1:0]              fwd_b;
  logic [rv_pkg::xlen-1:0] dec_rdata1;
  logic [rv_pkg::xlen-1:0] dec_rdata2;
  logic [rv_pkg::xlen-1:0] dec_imm;
  logic [4:0]              dec_rs1;
  logic [4:0]              dec_rs2;
  logic [4:0]              dec_rd;
  logic                    branch_taken;
  logic [rv_pkg::xlen-1:0] branch_target;
  logic [rv_pkg::xlen-1:0] ex_alu;
  logic [rv_pkg::xlen-1:0] ex_store;
  logic [rv_pkg::xlen-1:0] mem_rdata;
  logic [rv_pkg::xlen-1:0] wb_data;

  // ==========================================================================
  // pipeline registers
  // ==========================================================================
  logic [rv_pkg::xlen-1:0] if_id_pc;
  rv_pkg::instr_u          if_id_instr;

  logic                    id_ex_reg_write;
  logic                    id_ex_mem_read;
  logic                    id_ex_mem_write;
  logic                    id_ex_mem_to_reg;
  logic                    id_ex_alu_src;
  logic [2:0]              id_ex_alu_op;
  logic [4:0]              id_ex_rs1;
  logic [4:0]              id_ex_rs2;
  logic [4:0]              id_ex_rd;
  logic [rv_pkg::xlen-1:0] id_ex_rdata1;
  logic [rv_pkg::xlen-1:0] id_ex_rdata2;
  logic [rv_pkg::xlen-1:0] id_ex_imm;

  logic                    ex_mem_reg_write;
  logic                    ex_mem_mem_read;
  logic                    ex_mem_mem_write;
  logic                    ex_mem_mem_to_reg;
  logic [4:0]              ex_mem_rd;
  logic [rv_pkg::xlen-1:0] ex_mem_alu;
  logic [rv_pkg::xlen-1:0] ex_mem_store;

  logic                    mem_wb_reg_write;
  logic                    mem_wb_mem_to_reg;
  logic [4:0]              mem_wb_rd;
  logic [rv_pkg::xlen-1:0] mem_wb_alu;
  logic [rv_pkg::xlen-1:0] mem_wb_mem_data;

  always_ff @(posedge clk) begin
    // nothing enters decode while the core is parked.
    if (rst || !run || flush_if) begin
      if_id_instr <= '0;
    end else if (!stall) begin
      if_id_instr <= fetch_instr;
    end
    if (!stall) begin
      if_id_pc <= fetch_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex_reg_write  <= 1'b0;
      id_ex_mem_read   <= 1'b0;
      id_ex_mem_write  <= 1'b0;
      id_ex_mem_to_reg <= 1'b0;
      id_ex_alu_src    <= 1'b0;
      id_ex_alu_op     <= rv_pkg::alu_add;
      id_ex_rs1        <= 5'd0;
      id_ex_rs2        <= 5'd0;
      id_ex_rd         <= 5'd0;
    end else begin
      id_ex_reg_write  <= ctl_reg_write; // cleared by control on a stall.
      id_ex_mem_read   <= ctl_mem_read;
      id_ex_mem_write  <= ctl_mem_write;
      id_ex_mem_to_reg <= ctl_mem_to_reg;
      id_ex_alu_src    <= ctl_alu_src;
      id_ex_alu_op     <= ctl_alu_op;
      id_ex_rs1        <= dec_rs1;
      id_ex_rs2        <= dec_rs2;
      id_ex_rd         <= dec_rd;
    end
    id_ex_rdata1 <= dec_rdata1;
    id_ex_rdata2 <= dec_rdata2;
    id_ex_imm    <= dec_imm;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem_reg_write  <= 1'b0;
      ex_mem_mem_read   <= 1'b0;
      ex_mem_mem_write  <= 1'b0;
      ex_mem_mem_to_reg <= 1'b0;
      ex_mem_rd         <= 5'd0;
      mem_wb_reg_write  <= 1'b0;
      mem_wb_mem_to_reg <= 1'b0;
      mem_wb_rd         <= 5'd0;
    end else begin
      ex_mem_reg_write  <= id_ex_reg_write;
      ex_mem_mem_read   <= id_ex_mem_read;
      ex_mem_mem_write  <= id_ex_mem_write;
      ex_mem_mem_to_reg <= id_ex_mem_to_reg;
      ex_mem_rd         <= id_ex_rd;
      mem_wb_reg_write  <= ex_mem_reg_write;
      mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
      mem_wb_rd         <= ex_mem_rd;
    end
    ex_mem_alu      <= ex_alu;
    ex_mem_store    <= ex_store;
    mem_wb_alu      <= ex_mem_alu;
    mem_wb_mem_data <= mem_rdata;
  end

  assign wb_data = mem_wb_mem_to_reg ? mem_wb_mem_data : mem_wb_alu;

  // ==========================================================================
  // stages
  // ==========================================================================
  fetch_stage fetch_stage_inst (
    .clk           (clk),
    .rst           (rst),
    .run           (run),
    .stall         (stall),
    .pc_sel        (pc_sel),
    .branch_target (branch_target),
    .imem_we       (imem_we),
    .imem_addr     (imem_addr),
    .imem_wdata    (imem_wdata),
    .pc            (fetch_pc),
    .instr         (fetch_instr)
  );

  pipeline_control pipeline_control_inst (
    .clk              (clk),
    .rst              (rst),
    .if_id_instr      (if_id_instr),
    .id_ex_rs1        (id_ex_rs1),
    .id_ex_rs2        (id_ex_rs2),
    .id_ex_rd         (id_ex_rd),
    .id_ex_mem_read   (id_ex_mem_read),
    .id_ex_reg_write  (id_ex_reg_write),
    .ex_mem_rd        (ex_mem_rd),
    .ex_mem_reg_write (ex_mem_reg_write),
    .ex_mem_mem_read  (ex_mem_mem_read),
    .mem_wb_rd        (mem_wb_rd),
    .mem_wb_reg_write (mem_wb_reg_write),
    .branch_taken     (branch_taken),
    .reg_write        (ctl_reg_write),
    .mem_read         (ctl_mem_read),
    .mem_write        (ctl_mem_write),
    .mem_to_reg       (ctl_mem_to_reg),
    .alu_src          (ctl_alu_src),
    .alu_op           (ctl_alu_op),
    .stall            (stall),
    .pc_sel           (pc_sel),
    .flush_if         (flush_if),
    .fwd_a            (fwd_a),
    .fwd_b            (fwd_b)
  );

  decode_stage decode_stage_inst (
    .clk              (clk),
    .rst              (rst),
    .instr            (if_id_instr),
    .pc               (if_id_pc),
    .wb_we            (mem_wb_reg_write),
    .wb_rd            (mem_wb_rd),
    .wb_data          (wb_data),
    .ex_mem_reg_write (ex_mem_reg_write),
    .ex_mem_rd        (ex_mem_rd),
    .ex_mem_alu       (ex_mem_alu),
    .rdata1           (dec_rdata1),
    .rdata2           (dec_rdata2),
    .imm              (dec_imm),
    .rs1              (dec_rs1),
    .rs2              (dec_rs2),
    .rd               (dec_rd),
    .branch_taken     (branch_taken),
    .branch_target    (branch_target)
  );

  execute_stage execute_stage_inst (
    .alu_op      (id_ex_alu_op),
    .alu_src     (id_ex_alu_src),
    .rdata1      (id_ex_rdata1),
    .rdata2      (id_ex_rdata2),
    .imm         (id_ex_imm),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .ex_mem_alu  (ex_mem_alu),
    .wb_data     (wb_data),
    .alu_result  (ex_alu),
    .store_value (ex_store)
  );

  memory_stage memory_stage_inst (
    .clk         (clk),
    .rst         (rst),
    .mem_read    (ex_mem_mem_read),
    .mem_write   (ex_mem_mem_write),
    .addr        (ex_mem_alu),
    .wdata       (ex_mem_store),
    .rdata       (mem_rdata),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

endmodule

//--- bench/rv_pipeline_tb.sv
`timescale 1ns/1ns

module rv_pipeline_tb;

  localparam int data_depth    = 256;
  localparam int reset_cycles  = 16;
  localparam int idle_cycles   = 20;
  localparam int cycles_a_word = 20;

  logic                       clk;
  logic                       rst;
  logic                       run;
  logic                       imem_we;
  logic [rv_pkg::imem_aw-1:0] imem_addr;
  logic [rv_pkg::xlen-1:0]    imem_wdata;
  logic                       store_valid;
  logic [rv_pkg::xlen-1:0]    store_addr;
  logic [rv_pkg::xlen-1:0]    store_data;

  logic [31:0] tdata [data_depth];
  int          num_words;
  int          num_stores;
  int          store_base; // index of the first expected pair.
  int          stores_seen;
  int          errors;

  rv_pipeline rv_pipeline_inst (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_wdata  (imem_wdata),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

  always #50 clk = ~clk;

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAILED %s: got %h, expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d, stores seen: %0d of %0d", errors, stores_seen, num_stores);
  endtask

  // ==========================================================================
  // program loading and start
  // ==========================================================================
  // reset drops after the 16th edge, the program keeps loading while run is low.
  task automatic load_program();
    int last_cycle;
    last_cycle = (num_words + 1 > reset_cycles) ? num_words + 1 : reset_cycles;
    for (int cycle = 1; cycle <= last_cycle; cycle++) begin
      @(posedge clk);
      #5;
      rst = (cycle < reset_cycles);
      if (cycle <= num_words) begin
        imem_we    = 1'b1;
        imem_addr  = rv_pkg::imem_aw'(cycle - 1);
        imem_wdata = tdata[cycle];
      end else begin
        imem_we = 1'b0;
      end
    end
  endtask

  task automatic start_core();
    @(posedge clk);
    #5;
    run = 1'b1;
  endtask

  // ==========================================================================
  // store monitor
  // ==========================================================================
  always @(negedge clk) begin
    if (!rst && $isunknown(store_valid)) begin
      $display("store_valid is unknown after reset");
      errors++;
    end else if (store_valid === 1'b1) begin
      if (rst || !run) begin
        $display("a store appeared while the core was held in reset or parked");
        errors++;
      end else if (stores_seen >= num_stores) begin
        $display("unexpected extra store to address %h", store_addr);
        errors++;
      end else begin
        compare_word("store_addr", store_addr, tdata[store_base + 2 * stores_seen]);
        compare_word("store_data", store_data, tdata[store_base + 2 * stores_seen + 1]);
        stores_seen++;
      end
    end
  end

  initial begin : watchdog
    int limit;
    @(posedge clk); // the data file has been read by now.
    limit = reset_cycles + rv_pkg::imem_words + num_words * cycles_a_word + idle_cycles;
    repeat (limit) @(posedge clk);
    $display("timed out after %0d cycles, the expected stores never all arrived", limit);
    print_counts();
    $display("Test failures found");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    run         = 1'b0;
    imem_we     = 1'b0;
    imem_addr   = '0;
    imem_wdata  = '0;
    errors      = 0;
    stores_seen = 0;
    num_stores  = 0;
    store_base  = 0;

    $readmemh("bench/rv_testdata.txt", tdata);
    num_words = int'(tdata[0]);
    if (num_words >= 1 && num_words <= rv_pkg::imem_words) begin
      num_stores = int'(tdata[num_words + 1]);
      store_base = num_words + 2;
    end

    if (num_stores < 1 || store_base + 2 * num_stores > data_depth) begin
      $display("the test data file is missing or its counts are out of range");
      errors++;
    end else begin
      load_program();
      start_core();
      wait (stores_seen == num_stores);
      repeat (idle_cycles) @(posedge clk); // any further store is an error.
    end

    print_counts();
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- bench/rv_testdata.txt
// word count, one program word per line, store count,
// then the expected stores as store_addr store_data pairs.
00000021
05a00093 // 00 addi x1, x0, 90
ff900113 // 04 addi x2, x0, -7
002081b3 // 08 add  x3, x1, x2
00302023 // 0c sw   x3, 0(x0)
40208233 // 10 sub  x4, x1, x2
0020f2b3 // 14 and  x5, x1, x2
00402223 // 18 sw   x4, 4(x0)
00502423 // 1c sw   x5, 8(x0)
0040e333 // 20 or   x6, x1, x4
001123b3 // 24 slt  x7, x2, x1
0020a433 // 28 slt  x8, x1, x2
ff030493 // 2c addi x9, x6, -16
00602623 // 30 sw   x6, 12(x0)
00702823 // 34 sw   x7, 16(x0)
00802a23 // 38 sw   x8, 20(x0)
00902c23 // 3c sw   x9, 24(x0)
00402503 // 40 lw   x10, 4(x0)
001505b3 // 44 add  x11, x10, x1
00b02e23 // 48 sw   x11, 28(x0)
03700013 // 4c addi x0, x0, 55
02002023 // 50 sw   x0, 32(x0)
00318463 // 54 beq  x3, x3, +8 (taken)
02102223 // 58 sw   x1, 36(x0) (skipped)
00208463 // 5c beq  x1, x2, +8 (not taken)
02202423 // 60 sw   x2, 40(x0)
05300613 // 64 addi x12, x0, 83
00360463 // 68 beq  x12, x3, +8 (taken after an ALU result)
02c02623 // 6c sw   x12, 44(x0) (skipped)
00002683 // 70 lw   x13, 0(x0)
00368463 // 74 beq  x13, x3, +8 (taken after a load)
02d02823 // 78 sw   x13, 48(x0) (skipped)
02d02a23 // 7c sw   x13, 52(x0)
00000063 // 80 beq  x0, x0, 0 (parks the core)
0000000b
00000000 00000053
00000004 00000061
00000008 00000058
0000000c 0000007b
00000010 00000001
00000014 00000000
00000018 0000006b
0000001c 000000bb
00000020 00000000
00000028 fffffff9
00000034 00000053

//--- src.f
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/pipeline_control.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/rv_pipeline.sv
bench/rv_pipeline_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_pipeline_tb \
  -f src.f \
  -o rv_pipeline_sim

./obj_dir/rv_pipeline_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
